// File: Makefile
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_top
RTL_TOP    = alu_pipe_top
FILELIST   = alu_pipe.f
OBJ_DIR    = obj_dir
PASS_MSG   = No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: alu_pipe.f
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/issue_if.sv
rtl/bypass_if.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/result_pipe.sv
rtl/alu_pipe_top.sv
bench/pipe_assert.sv
bench/tb_top.sv

// File: bench/pipe_assert.sv
// pipe_assert
// writeback strobe properties bound onto the pipeline top level

`timescale 1ns/1ps

module pipe_assert import isa_pkg::*; (
  input logic      clk,
  input logic      reset,
  input logic      inst_valid,
  input logic      wb_valid,
  input reg_addr_t wb_rd
);

  // strobe must be known once out of reset
  a_wb_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(wb_valid))
    else $error("wb_valid is unknown");

  a_wb_rd_nonzero: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> (wb_rd != '0))
    else $error("writeback strobe names x0");

  // issue strobe sits four edges back for the fixed latency
  a_wb_latency: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> $past(inst_valid, 4))
    else $error("writeback without an instruction four cycles earlier");

endmodule

// File: bench/tb_top.sv
// tb_top
// random and directed instruction streams for the execute pipeline
// with every writeback checked against a reference model for value, order and latency

`timescale 1ns/1ps

module tb_top import isa_pkg::*, pipe_pkg::*; ();

  localparam int unsigned SEED        = 32'h2c6;
  localparam int unsigned LATENCY     = 4;
  localparam int          DRAIN_LIMIT = 40;

  // funct3 of add, sub, and, or, xor, sll, srl
  localparam funct3_t OP_F3 [7] = '{F3_ADD_SUB, F3_ADD_SUB, F3_AND, F3_OR, F3_XOR,
                                    F3_SLL, F3_SRL};
  localparam logic [6:0] DROPPED_OPS [10] = '{op_load, op_store, op_branch, op_jal, op_jalr,
                                              op_lui, op_auipc, op_system, 7'b0001111,
                                              7'b1111111};
  // slt, sltu, sra, alt and, mul, slti, sltiu, srai, slli with bad upper bits
  localparam inst_t UNSUPPORTED [9] = '{
    {F7_BASE, 5'd4, 5'd3, F3_SLT, 5'd9, op_reg},
    {F7_BASE, 5'd4, 5'd3, F3_SLTU, 5'd9, op_reg},
    {F7_ALT, 5'd4, 5'd3, F3_SRL, 5'd9, op_reg},
    {F7_ALT, 5'd4, 5'd3, F3_AND, 5'd9, op_reg},
    {7'b0000001, 5'd4, 5'd3, F3_ADD_SUB, 5'd9, op_reg},
    {12'h123, 5'd3, F3_SLT, 5'd9, op_imm},
    {12'h123, 5'd3, F3_SLTU, 5'd9, op_imm},
    {F7_ALT, 5'd4, 5'd3, F3_SRL, 5'd9, op_imm},
    {7'b0000100, 5'd4, 5'd3, F3_SLL, 5'd9, op_imm}
  };

  logic      clk = 1'b0;
  logic      reset;
  logic      inst_valid;
  inst_t     inst;
  logic      wb_valid;
  reg_addr_t wb_rd;
  word_t     wb_data;

  word_t       arch [NUM_REGS];  // architectural registers of the model
  reg_addr_t   exp_rd_q [$];
  word_t       exp_data_q [$];
  int unsigned exp_edge_q [$];   // edge that sampled the instruction
  int unsigned edge_count = 0;
  int          errors = 0;
  int          checks = 0;

  alu_pipe_top uut (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
  );

  bind alu_pipe_top pipe_assert u_pipe_assert (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd)
  );

  always #2 clk = ~clk;

  always @(posedge clk) edge_count <= edge_count + 1;

  // RV32I semantics of the kept subset; returns 1 when rd gets written
  function automatic logic predict(input inst_t in, output reg_addr_t rd, output word_t val);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      a;
    word_t      b;
    logic       ok;
    opc = in[6:0];
    f3  = in[14:12];
    f7  = in[31:25];
    rd  = in[11:7];
    a   = arch[in[19:15]];
    b   = (opc == 7'b0010011) ? {{20{in[31]}}, in[31:20]} : arch[in[24:20]];
    ok  = 1'b1;
    val = '0;
    if (opc == 7'b0110011 && f7 == 7'b0100000 && f3 == 3'b000) begin
      val = a - b;
    end else if ((opc == 7'b0110011 && f7 != 7'b0000000) ||
                 (opc != 7'b0110011 && opc != 7'b0010011)) begin
      ok = 1'b0;
    end else begin
      case (f3)
        3'b000:  val = a + b;
        3'b100:  val = a ^ b;
        3'b110:  val = a | b;
        3'b111:  val = a & b;
        3'b001: begin
          val = a << b[4:0];
          ok  = (f7 == 7'b0);
        end
        3'b101: begin
          val = a >> b[4:0];  // logical as sra is not kept
          ok  = (f7 == 7'b0);
        end
        default: ok = 1'b0;   // slt, sltu
      endcase
    end
    if (rd == '0)
      ok = 1'b0;
    if (ok)
      arch[rd] = val;
    return ok;
  endfunction

  // op 0..6 is add, sub, and, or, xor, sll, srl; sub only exists as R form
  function automatic inst_t alu_inst(input int op, input logic imm_form, input reg_addr_t rd,
                                     input reg_addr_t rs1, input reg_addr_t rs2,
                                     input imm12_t imm);
    imm12_t i_field;
    i_field = (op >= 5) ? {7'b0, imm[4:0]} : imm;  // shifts carry shamt only
    if (imm_form && op != 1)
      return {i_field, rs1, OP_F3[op], rd, op_imm};
    return {(op == 1) ? F7_ALT : F7_BASE, rs2, rs1, OP_F3[op], rd, op_reg};
  endfunction

  function automatic inst_t random_alu(input reg_addr_t rd, input reg_addr_t rs1,
                                       input reg_addr_t rs2);
    return alu_inst($urandom_range(0, 6), 1'($urandom), rd, rs1, rs2, 12'($urandom));
  endfunction

  task automatic send(input inst_t in);
    reg_addr_t rd;
    word_t     val;
    @(posedge clk);
    #0.5;
    inst_valid = 1'b1;
    inst       = in;
    if (predict(in, rd, val)) begin
      exp_rd_q.push_back(rd);
      exp_data_q.push_back(val);
      exp_edge_q.push_back(edge_count + 1);
    end
  endtask

  task automatic idle();
    @(posedge clk);
    #0.5;
    inst_valid = 1'b0;
    inst       = $urandom;  // garbage under a low strobe
  endtask

  task automatic drop_head();
    void'(exp_rd_q.pop_front());
    void'(exp_data_q.pop_front());
    void'(exp_edge_q.pop_front());
  endtask

  // outputs sampled mid-cycle belong to the next rising edge
  always @(negedge clk) begin
    if (wb_valid === 1'b1) begin
      assert (exp_rd_q.size() != 0)
        else begin
          errors++;
          $display("unexpected writeback to x%0d at %0t", wb_rd, $time);
        end
      if (exp_rd_q.size() != 0) begin
        checks++;
        assert (wb_rd == exp_rd_q[0] && wb_data == exp_data_q[0])
          else begin
            errors++;
            $display("FAILED %0t: got x%0d = %h, expected x%0d = %h", $time,
                     wb_rd, wb_data, exp_rd_q[0], exp_data_q[0]);
          end
        assert (edge_count + 1 == exp_edge_q[0] + LATENCY)
          else begin
            errors++;
            $display("FAILED %0t: writeback at edge %0d, expected edge %0d", $time,
                     edge_count + 1, exp_edge_q[0] + LATENCY);
          end
        drop_head();
      end
    end else if (exp_rd_q.size() != 0) begin
      assert (exp_edge_q[0] + LATENCY > edge_count + 1)
        else begin
          errors++;
          $display("missing writeback to x%0d at %0t", exp_rd_q[0], $time);
          drop_head();
        end
    end
  end

  initial begin
    int r;
    int f;
    void'($urandom(SEED));
    reset      = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    for (int i = 0; i < NUM_REGS; i++)
      arch[i] = '0;
    repeat (16) @(posedge clk);
    #0.5;
    reset = 1'b0;
    repeat (4) idle();

    // give every register a value through addi from x0
    for (int i = 1; i < NUM_REGS; i++)
      send(alu_inst(0, 1'b1, 5'(i), '0, '0, 12'($urandom)));

    // random traffic with occasional rd x0 and gaps
    repeat (300) begin
      if ($urandom_range(0, 7) == 0)
        idle();
      else
        send(random_alu(5'($urandom), 5'($urandom), 5'($urandom)));
    end

    // producer and consumer at distance d through rs1 or rs2
    for (int d = 1; d <= 5; d++) begin
      repeat (12) begin
        r = $urandom_range(1, 31);
        send(random_alu(5'(r), 5'($urandom), 5'($urandom)));
        repeat (d - 1) begin
          f = ((r + $urandom_range(0, 29)) % 31) + 1;  // never r
          if ($urandom_range(0, 3) == 0)
            idle();
          else
            send(random_alu(5'(f), 5'($urandom), 5'($urandom)));
        end
        if ($urandom_range(0, 1) == 0)
          send(random_alu(5'($urandom_range(1, 31)), 5'(r), 5'($urandom)));
        else
          send(alu_inst($urandom_range(0, 6), 1'b0, 5'($urandom_range(1, 31)),
                        5'($urandom), 5'(r), '0));
      end
    end

    // bubbles from rd x0, dropped opcodes and unsupported funct codes
    repeat (6) send(random_alu(5'd0, 5'($urandom), 5'($urandom)));
    foreach (DROPPED_OPS[i])
      send({25'($urandom), DROPPED_OPS[i]});
    foreach (UNSUPPORTED[i])
      send(UNSUPPORTED[i]);
    repeat (3) idle();
    send(alu_inst(0, 1'b1, 5'd0, 5'd1, '0, 12'h7ff));
    send(alu_inst(3, 1'b0, 5'd12, 5'd0, 5'd0, '0));  // x0 must read zero
    send(alu_inst(0, 1'b1, 5'd13, 5'd0, '0, '0));
    send(alu_inst(2, 1'b0, 5'd14, 5'd0, 5'd13, '0));

    idle();
    for (int i = 0; i < DRAIN_LIMIT && exp_rd_q.size() != 0; i++)
      @(posedge clk);
    assert (exp_rd_q.size() == 0)
      else begin
        errors++;
        $display("timeout with %0d writebacks still pending", exp_rd_q.size());
      end
    repeat (8) @(posedge clk);
    $display("writebacks checked: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// File: rtl/alu_pipe_top.sv
// alu_pipe_top
// four stage integer execute pipeline of decode, execute, memory slot and writeback
// fixed four cycle latency from instruction strobe to writeback strobe

`timescale 1ns/1ps

module alu_pipe_top import isa_pkg::*, pipe_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      inst_valid,
  input  inst_t     inst,
  output logic      wb_valid,
  output reg_addr_t wb_rd,
  output word_t     wb_data
);

  logic      ex_we;
  reg_addr_t ex_rd;
  word_t     ex_data;

  issue_if  iss ();
  bypass_if byp ();

  decode_stage u_decode (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .wr         (byp.wr),
    .iss        (iss.src)
  );

  execute_stage u_execute (
    .iss     (iss.dst),
    .byp     (byp.fwd),
    .ex_we   (ex_we),
    .ex_rd   (ex_rd),
    .ex_data (ex_data)
  );

  result_pipe u_result (
    .clk     (clk),
    .reset   (reset),
    .ex_we   (ex_we),
    .ex_rd   (ex_rd),
    .ex_data (ex_data),
    .byp     (byp.src)
  );

  assign wb_valid = byp.wb_we;  // same tap that writes the register file
  assign wb_rd    = byp.wb_rd;
  assign wb_data  = byp.wb_data;

endmodule

// File: rtl/bypass_if.sv
// bypass_if
// mem, wb and far-linking result taps of the result pipe

`timescale 1ns/1ps

interface bypass_if import isa_pkg::*, pipe_pkg::*; ();

  logic      mem_we;
  reg_addr_t mem_rd;
  word_t     mem_data;
  logic      wb_we;     // also the register file write port
  reg_addr_t wb_rd;
  word_t     wb_data;
  logic      far_we;
  reg_addr_t far_rd;
  word_t     far_data;

  modport src (
    output mem_we, mem_rd, mem_data, wb_we, wb_rd, wb_data, far_we, far_rd, far_data
  );

  modport fwd (
    input mem_we, mem_rd, mem_data, wb_we, wb_rd, wb_data, far_we, far_rd, far_data
  );

  modport wr (input wb_we, wb_rd, wb_data);

endinterface

// File: rtl/decode_stage.sv
// decode_stage
// instruction register, decoder, immediate generation, register read
// and the ID/EX register; unsupported encodings and rd zero become bubbles

`timescale 1ns/1ps

module decode_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  inst_valid,
  input  inst_t inst,
  bypass_if.wr  wr,
  issue_if.src  iss
);

  logic      if_valid;
  inst_t     if_inst;

  opcode_e   opcode;
  funct3_t   funct3;
  funct7_t   funct7;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  imm12_t    imm12;
  word_t     imm;

  logic      f3_known;
  logic      is_shift;
  logic      dec_ok;
  logic      dec_valid;
  logic      dec_use_imm;
  alu_op_e   dec_op;
  alu_op_e   f3_op;
  word_t     rf_rs1_data;
  word_t     rf_rs2_data;

  // instruction register; a low strobe loads a bubble
  always_ff @(posedge clk) begin
    if (reset) begin
      if_valid <= 1'b0;
      if_inst  <= '0;
    end else begin
      if_valid <= inst_valid;
      if_inst  <= inst_valid ? inst : '0;
    end
  end

  assign opcode = opcode_e'(if_inst[6:0]);
  assign rd     = if_inst[11:7];
  assign funct3 = if_inst[14:12];
  assign rs1    = if_inst[19:15];
  assign funct7 = if_inst[31:25];
  assign imm12  = if_inst[31:20];
  assign rs2    = (opcode == op_reg) ? if_inst[24:20] : '0;  // I-type has no rs2

  assign imm = {{20{imm12[11]}}, imm12};  // sign-extended I field

  assign f3_known = (funct3 != F3_SLT) && (funct3 != F3_SLTU);
  assign is_shift = (funct3 == F3_SLL) || (funct3 == F3_SRL);

  // funct3 alone picks the op for both formats
  always_comb begin
    case (funct3)
      F3_SLL:  f3_op = alu_sll;
      F3_XOR:  f3_op = alu_xor;
      F3_SRL:  f3_op = alu_srl;
      F3_OR:   f3_op = alu_or;
      F3_AND:  f3_op = alu_and;
      default: f3_op = alu_add;
    endcase
  end

  always_comb begin
    dec_ok      = 1'b0;
    dec_op      = f3_op;
    dec_use_imm = 1'b0;
    case (opcode)
      op_reg: begin
        if (funct7 == F7_ALT) begin
          dec_ok = (funct3 == F3_ADD_SUB);
          dec_op = alu_sub;
        end else begin
          dec_ok = f3_known && (funct7 == F7_BASE);
        end
      end
      op_imm: begin
        dec_use_imm = 1'b1;
        dec_ok      = f3_known && (!is_shift || (funct7 == F7_BASE));  // srai dropped
      end
      default:
        dec_ok = 1'b0;
    endcase
  end

  assign dec_valid = if_valid && dec_ok && (rd != '0);

  reg_file u_reg_file (
    .clk      (clk),
    .reset    (reset),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data),
    .wr       (wr)
  );

  // ID/EX register
  always_ff @(posedge clk) begin
    if (reset || !dec_valid) begin
      iss.valid    <= 1'b0;
      iss.rd       <= '0;
      iss.rs1      <= '0;
      iss.rs2      <= '0;
      iss.alu_op   <= alu_add;
      iss.use_imm  <= 1'b0;
      iss.rs1_data <= '0;
      iss.rs2_data <= '0;
      iss.imm      <= '0;
    end else begin
      iss.valid    <= 1'b1;
      iss.rd       <= rd;
      iss.rs1      <= rs1;
      iss.rs2      <= rs2;
      iss.alu_op   <= dec_op;
      iss.use_imm  <= dec_use_imm;
      iss.rs1_data <= rf_rs1_data;
      iss.rs2_data <= rf_rs2_data;
      iss.imm      <= imm;
    end
  end

endmodule

// File: rtl/execute_stage.sv
// execute_stage
// operand forwarding from the mem, wb and far taps, operand mux and ALU
// purely combinational between ID/EX and EX/MEM

`timescale 1ns/1ps

module execute_stage import isa_pkg::*, pipe_pkg::*; (
  issue_if.dst      iss,
  bypass_if.fwd     byp,
  output logic      ex_we,
  output reg_addr_t ex_rd,
  output word_t     ex_data
);

  fwd_src_e rs1_src;
  fwd_src_e rs2_src;
  word_t    op_a;
  word_t    rs2_val;
  word_t    op_b;
  shamt_t   shamt;
  word_t    alu_out;

  // youngest producer wins with mem before wb before far
  function automatic fwd_src_e fwd_sel(reg_addr_t rs);
    fwd_src_e sel;
    sel = fwd_reg;
    if (rs != '0) begin
      if (byp.mem_we && (byp.mem_rd == rs))
        sel = fwd_mem;
      else if (byp.wb_we && (byp.wb_rd == rs))
        sel = fwd_wb;
      else if (byp.far_we && (byp.far_rd == rs))
        sel = fwd_far;
    end
    return sel;
  endfunction

  function automatic word_t fwd_mux(fwd_src_e sel, word_t reg_data);
    word_t val;
    case (sel)
      fwd_mem: val = byp.mem_data;
      fwd_wb:  val = byp.wb_data;
      fwd_far: val = byp.far_data;
      default: val = reg_data;
    endcase
    return val;
  endfunction

  // taps are read inside the functions
  always_comb begin
    rs1_src = fwd_sel(iss.rs1);
    rs2_src = fwd_sel(iss.rs2);
    op_a    = fwd_mux(rs1_src, iss.rs1_data);
    rs2_val = fwd_mux(rs2_src, iss.rs2_data);
  end

  assign op_b    = iss.use_imm ? iss.imm : rs2_val;
  assign shamt   = op_b[4:0];

  always_comb begin
    case (iss.alu_op)
      alu_add: alu_out = op_a + op_b;
      alu_sub: alu_out = op_a - op_b;
      alu_and: alu_out = op_a & op_b;
      alu_or:  alu_out = op_a | op_b;
      alu_xor: alu_out = op_a ^ op_b;
      alu_sll: alu_out = op_a << shamt;
      alu_srl: alu_out = op_a >> shamt;  // logical
      default: alu_out = '0;
    endcase
  end

  assign ex_we   = iss.valid;
  assign ex_rd   = iss.rd;
  assign ex_data = alu_out;

endmodule

// File: rtl/isa_pkg.sv
// isa_pkg
// RV32I instruction word types, opcode encodings and funct codes
// used by the integer execute pipeline decoder

package isa_pkg;

  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;
  typedef logic [11:0] imm12_t;

  // major opcodes; only op_reg and op_imm execute here
  typedef enum logic [6:0] {
    op_reg    = 7'b0110011,
    op_imm    = 7'b0010011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_system = 7'b1110011
  } opcode_e;

  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;  // not supported
  localparam funct3_t F3_SLTU    = 3'b011;  // not supported
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL     = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  localparam funct7_t F7_BASE = 7'b0000000;
  localparam funct7_t F7_ALT  = 7'b0100000;  // sub, sra (sra dropped)

endpackage

// File: rtl/issue_if.sv
// issue_if
// decoded instruction handed from decode to execute (the ID/EX register)

`timescale 1ns/1ps

interface issue_if import isa_pkg::*, pipe_pkg::*; ();

  logic      valid;     // writes a register
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  alu_op_e   alu_op;
  logic      use_imm;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     imm;

  modport src (
    output valid, rd, rs1, rs2, alu_op, use_imm, rs1_data, rs2_data, imm
  );

  modport dst (
    input valid, rd, rs1, rs2, alu_op, use_imm, rs1_data, rs2_data, imm
  );

endinterface

// File: rtl/pipe_pkg.sv
// pipe_pkg
// datapath word, ALU operation and forwarding source types

package pipe_pkg;

  localparam int NUM_REGS = 32;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  shamt_t;  // low bits of the second operand

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl
  } alu_op_e;

  // operand source as encoded in the forwarding mux
  typedef enum logic [1:0] {
    fwd_reg = 2'd0,
    fwd_wb  = 2'd1,
    fwd_mem = 2'd2,
    fwd_far = 2'd3
  } fwd_src_e;

endpackage

// File: rtl/reg_file.sv
// reg_file
// 32 x 32 register file, two async read ports, one write port from wb tap
// x0 reads zero and is never written; no write-through on reads

`timescale 1ns/1ps

module reg_file import isa_pkg::*, pipe_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output word_t     rs1_data,
  output word_t     rs2_data,
  bypass_if.wr      wr
);

  word_t regs [NUM_REGS];

  assign rs1_data = regs[rs1];  // stored value only
  assign rs2_data = regs[rs2];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.wb_we && (wr.wb_rd != '0)) begin
      regs[wr.wb_rd] <= wr.wb_data;
    end
  end

endmodule

// File: rtl/result_pipe.sv
// result_pipe
// EX/MEM, MEM/WB and far-linking registers holding in-flight results
// each register is a bypass tap; MEM/WB is also the writeback

`timescale 1ns/1ps

module result_pipe import isa_pkg::*, pipe_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      ex_we,
  input  reg_addr_t ex_rd,
  input  word_t     ex_data,
  bypass_if.src     byp
);

  logic      mem_we, wb_we, far_we;
  reg_addr_t mem_rd, wb_rd, far_rd;
  word_t     mem_data, wb_data, far_data;

  // one shift per edge with no stalls
  always_ff @(posedge clk) begin
    if (reset) begin
      mem_we   <= 1'b0;
      mem_rd   <= '0;
      mem_data <= '0;
      wb_we    <= 1'b0;
      wb_rd    <= '0;
      wb_data  <= '0;
      far_we   <= 1'b0;
      far_rd   <= '0;
      far_data <= '0;
    end else begin
      mem_we   <= ex_we;
      mem_rd   <= ex_rd;
      mem_data <= ex_data;
      wb_we    <= mem_we;   // memory slot passes through
      wb_rd    <= mem_rd;
      wb_data  <= mem_data;
      far_we   <= wb_we;    // value written to the register file this edge
      far_rd   <= wb_rd;
      far_data <= wb_data;
    end
  end

  assign byp.mem_we   = mem_we;
  assign byp.mem_rd   = mem_rd;
  assign byp.mem_data = mem_data;
  assign byp.wb_we    = wb_we;
  assign byp.wb_rd    = wb_rd;
  assign byp.wb_data  = wb_data;
  assign byp.far_we   = far_we;
  assign byp.far_rd   = far_rd;
  assign byp.far_data = far_data;

endmodule
